//--- include/huff18_settings.svh
`ifndef HUFF18_SETTINGS_SVH
`define HUFF18_SETTINGS_SVH

// longest codeword held in the table
`define HUFF_MAX_CODE_LEN 10

// table 18 escape width
`define HUFF_LINBITS 3
`define HUFF_ESC_VALUE 15

`define HUFF_SAMPLE_WIDTH 16

`endif

//--- verilog/huff18_pkg.sv
`include "huff18_settings.svh"

package huff18_pkg;

	// absolute value of one table entry, 0 to 15
	typedef logic [$clog2(`HUFF_ESC_VALUE + 1)-1:0] abs_t;

	// number of code bits collected so far
	typedef logic [$clog2(`HUFF_MAX_CODE_LEN + 1)-1:0] code_len_t;

	// first received bit sits in the msb
	typedef logic [`HUFF_MAX_CODE_LEN-1:0] code_bits_t;

	typedef logic [`HUFF_LINBITS-1:0] linval_t;

	typedef logic signed [`HUFF_SAMPLE_WIDTH-1:0] sample_t;

endpackage

//--- verilog/huff18_table.sv
`timescale 1ns/1ps

module huff18_table import huff18_pkg::*; (
	input  code_bits_t code_bits,
	input  code_len_t  code_len,
	output logic       match,
	output abs_t       x_abs,
	output abs_t       y_abs
);

	logic [7:0] xy;   // {x, y}, one hex digit each

	assign x_abs = xy[7:4];
	assign y_abs = xy[3:0];

	always_comb begin
		match = 1'b1;
		xy = 8'h00;
		case (code_len)
			4'd1: begin
				case (code_bits[9])
					1'b1:    xy = 8'h00;
					default: match = 1'b0;
				endcase
			end
			4'd3: begin
				case (code_bits[9:7])
					3'b011:  xy = 8'h10;
					default: match = 1'b0;
				endcase
			end
			4'd4: begin
				case (code_bits[9:6])
					4'b0101: xy = 8'h01;
					4'b0100: xy = 8'h11;
					default: match = 1'b0;
				endcase
			end
			4'd6: begin
				case (code_bits[9:4])
					6'b001110: xy = 8'h02;
					6'b001100: xy = 8'h12;
					6'b001111: xy = 8'h20;
					6'b001101: xy = 8'h21;
					default:   match = 1'b0;
				endcase
			end
			4'd7: begin
				case (code_bits[9:3])
					7'b0010100: xy = 8'h13;
					7'b0010111: xy = 8'h22;
					7'b0010101: xy = 8'h31;
					default:    match = 1'b0;
				endcase
			end
			4'd8: begin
				case (code_bits[9:2])
					8'b00101100: xy = 8'h03;
					8'b00100011: xy = 8'h14;
					8'b00001001: xy = 8'h1f;
					8'b00100110: xy = 8'h23;
					8'b00101101: xy = 8'h30;
					8'b00100111: xy = 8'h32;
					8'b00100100: xy = 8'h41;
					8'b00011110: xy = 8'h51;
					8'b00001010: xy = 8'hf1;
					8'b00000111: xy = 8'hf2;
					8'b00000011: xy = 8'hff;   // both escaped
					default:     match = 1'b0;
				endcase
			end
			4'd9: begin
				case (code_bits[9:1])
					9'b001001010: xy = 8'h04;
					9'b000111111: xy = 8'h05;
					9'b000010001: xy = 8'h0f;
					9'b000111110: xy = 8'h15;
					9'b000110101: xy = 8'h16;
					9'b000101111: xy = 8'h17;
					9'b001000011: xy = 8'h24;
					9'b000111010: xy = 8'h25;
					9'b000010000: xy = 8'h2f;
					9'b001000101: xy = 8'h33;
					9'b001000000: xy = 8'h34;
					9'b001001011: xy = 8'h40;
					9'b001000100: xy = 8'h42;
					9'b001000001: xy = 8'h43;
					9'b000001001: xy = 8'h4f;
					9'b001000010: xy = 8'h50;
					9'b000111011: xy = 8'h52;
					9'b000111000: xy = 8'h53;
					9'b000110110: xy = 8'h61;
					9'b000110100: xy = 8'h62;
					9'b000110000: xy = 8'h71;
					9'b000001100: xy = 8'hf0;
					9'b000001011: xy = 8'hf3;
					9'b000001010: xy = 8'hf4;
					default:      match = 1'b0;
				endcase
			end
			4'd10: begin
				case (code_bits[9:0])
					10'b0001101110: xy = 8'h06;
					10'b0001011101: xy = 8'h07;
					10'b0001010011: xy = 8'h18;
					10'b0001001011: xy = 8'h19;
					10'b0001000100: xy = 8'h1a;
					10'b0001100111: xy = 8'h26;
					10'b0001011010: xy = 8'h27;
					10'b0001001000: xy = 8'h29;
					10'b0001110010: xy = 8'h35;
					10'b0001100011: xy = 8'h36;
					10'b0001010111: xy = 8'h37;
					10'b0000011010: xy = 8'h3f;
					10'b0001110011: xy = 8'h44;
					10'b0001100101: xy = 8'h45;
					10'b0001100110: xy = 8'h54;
					10'b0000010000: xy = 8'h5f;
					10'b0001101111: xy = 8'h60;
					10'b0001100100: xy = 8'h63;
					10'b0000001010: xy = 8'h6f;
					10'b0001100010: xy = 8'h70;
					10'b0001011011: xy = 8'h72;
					10'b0001011000: xy = 8'h73;
					10'b0000001000: xy = 8'h7f;
					10'b0001010101: xy = 8'h80;
					10'b0001010100: xy = 8'h81;
					10'b0001010001: xy = 8'h82;
					10'b0000000111: xy = 8'h8f;
					10'b0001001100: xy = 8'h91;
					10'b0001001001: xy = 8'h92;
					10'b0001000011: xy = 8'ha2;
					10'b0000000100: xy = 8'haf;
					10'b0000010001: xy = 8'hf5;
					10'b0000001011: xy = 8'hf6;
					10'b0000001001: xy = 8'hf7;
					default:        match = 1'b0;
				endcase
			end
			default: match = 1'b0;   // no codes of length 2 or 5
		endcase
	end

endmodule

//--- verilog/hcode_matcher.sv
`timescale 1ns/1ps
`include "huff18_settings.svh"

module hcode_matcher import huff18_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  logic       in_bit,
	input  logic       pair_done,
	output code_bits_t code_bits,
	output code_len_t  code_len,
	input  logic       match,
	input  abs_t       x_abs,
	input  abs_t       y_abs,
	output logic       pair_valid,
	output abs_t       held_x_abs,
	output abs_t       held_y_abs,
	output logic       tail_valid,
	output logic       tail_bit,
	output logic       code_error
);

	code_bits_t code_q;
	code_len_t  count;
	logic       code_strobe;
	logic       code_full;

	// a bit in the release cycle already belongs to the next codeword
	assign code_strobe = in_valid && (!pair_valid || pair_done);
	assign tail_valid = in_valid && pair_valid && !pair_done;
	assign tail_bit = in_bit;

	assign code_full = (count == code_len_t'(`HUFF_MAX_CODE_LEN - 1));

	// table sees the code as it stands after the incoming bit
	assign code_len = count + 1'b1;

	always_comb begin
		code_bits = code_q;
		code_bits[`HUFF_MAX_CODE_LEN - 1 - count] = in_bit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			pair_valid <= 1'b0;
			code_error <= 1'b0;
		end else begin
			code_error <= 1'b0;
			if (pair_done)
				pair_valid <= 1'b0;
			if (code_strobe) begin
				if (match) begin
					pair_valid <= 1'b1;
					count <= '0;
				end else if (code_full) begin
					count <= '0;          // give up and restart matching
					code_error <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	// stale low bits are never looked at, the table slices by length
	always_ff @(posedge clk) begin
		if (code_strobe && !match)
			code_q <= code_bits;
		if (code_strobe && match) begin
			held_x_abs <= x_abs;
			held_y_abs <= y_abs;
		end
	end

endmodule

//--- verilog/tail_parser.sv
`timescale 1ns/1ps
`include "huff18_settings.svh"

module tail_parser import huff18_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    pair_valid,
	input  abs_t    x_abs,
	input  abs_t    y_abs,
	input  logic    tail_valid,
	input  logic    tail_bit,
	output logic    pair_done,
	output sample_t x_val,
	output sample_t y_val
);

	localparam int CNT_W = $clog2(`HUFF_LINBITS + 1);
	localparam logic [CNT_W-1:0] LIN_FULL = `HUFF_LINBITS;

	logic [CNT_W-1:0] x_lin_cnt, y_lin_cnt;
	logic             x_sign_seen, y_sign_seen;
	linval_t          x_lin, y_lin;
	logic             x_sign, y_sign;
	logic             x_esc, y_esc;
	logic             x_lin_open, x_sign_open;
	logic             y_lin_open, y_sign_open;
	sample_t          x_mag, y_mag;

	assign x_esc = (x_abs == abs_t'(`HUFF_ESC_VALUE));
	assign y_esc = (y_abs == abs_t'(`HUFF_ESC_VALUE));

	// fields still waiting for bits
	assign x_lin_open = x_esc && (x_lin_cnt != LIN_FULL);
	assign x_sign_open = (x_abs != '0) && !x_sign_seen;
	assign y_lin_open = y_esc && (y_lin_cnt != LIN_FULL);
	assign y_sign_open = (y_abs != '0) && !y_sign_seen;

	assign pair_done = pair_valid && !x_lin_open && !x_sign_open
		&& !y_lin_open && !y_sign_open;

	always_ff @(posedge clk) begin
		if (rst || pair_done) begin
			x_lin_cnt <= '0;
			y_lin_cnt <= '0;
			x_sign_seen <= 1'b0;
			y_sign_seen <= 1'b0;
		end else if (tail_valid) begin
			if (x_lin_open)
				x_lin_cnt <= x_lin_cnt + 1'b1;
			else if (x_sign_open)
				x_sign_seen <= 1'b1;
			else if (y_lin_open)
				y_lin_cnt <= y_lin_cnt + 1'b1;
			else if (y_sign_open)
				y_sign_seen <= 1'b1;
		end
	end

	// linbits arrive msb first
	always_ff @(posedge clk) begin
		if (tail_valid) begin
			if (x_lin_open)
				x_lin <= {x_lin[`HUFF_LINBITS-2:0], tail_bit};
			else if (x_sign_open)
				x_sign <= tail_bit;
			else if (y_lin_open)
				y_lin <= {y_lin[`HUFF_LINBITS-2:0], tail_bit};
			else if (y_sign_open)
				y_sign <= tail_bit;
		end
	end

	assign x_mag = sample_t'(x_abs) + (x_esc ? sample_t'(x_lin) : sample_t'(0));
	assign y_mag = sample_t'(y_abs) + (y_esc ? sample_t'(y_lin) : sample_t'(0));

	assign x_val = x_sign ? -x_mag : x_mag;   // zero magnitude stays zero
	assign y_val = y_sign ? -y_mag : y_mag;

endmodule

//--- verilog/huff18_decoder.sv
`timescale 1ns/1ps

module huff18_decoder import huff18_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  logic    in_bit,
	output logic    out_valid,
	output sample_t x_val,
	output sample_t y_val,
	output logic    code_error
);

	code_bits_t code_bits;
	code_len_t  code_len;
	logic       match;
	abs_t       tbl_x_abs, tbl_y_abs;
	logic       pair_valid;
	abs_t       held_x_abs, held_y_abs;
	logic       tail_valid;
	logic       tail_bit;
	logic       pair_done;

	assign out_valid = pair_done;   // release cycle is the output cycle

	hcode_matcher i_matcher (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_bit     (in_bit),
		.pair_done  (pair_done),
		.code_bits  (code_bits),
		.code_len   (code_len),
		.match      (match),
		.x_abs      (tbl_x_abs),
		.y_abs      (tbl_y_abs),
		.pair_valid (pair_valid),
		.held_x_abs (held_x_abs),
		.held_y_abs (held_y_abs),
		.tail_valid (tail_valid),
		.tail_bit   (tail_bit),
		.code_error (code_error)
	);

	huff18_table i_table (
		.code_bits (code_bits),
		.code_len  (code_len),
		.match     (match),
		.x_abs     (tbl_x_abs),
		.y_abs     (tbl_y_abs)
	);

	tail_parser i_parser (
		.clk        (clk),
		.rst        (rst),
		.pair_valid (pair_valid),
		.x_abs      (held_x_abs),
		.y_abs      (held_y_abs),
		.tail_valid (tail_valid),
		.tail_bit   (tail_bit),
		.pair_done  (pair_done),
		.x_val      (x_val),
		.y_val      (y_val)
	);

endmodule

//--- bench/tb_huff18_decoder.sv
`timescale 1ns/1ps

module tb_huff18_decoder import huff18_pkg::*; ();

	localparam int MAX_REC = 64;
	localparam int TIMEOUT = 100;   // cycles, covers 16 bits with 3 idle cycles each

	logic    clk;
	logic    rst;
	logic    in_valid;
	logic    in_bit;
	logic    out_valid;
	logic    code_error;
	sample_t x_val;
	sample_t y_val;

	logic [8*24-1:0] rec_name [MAX_REC];
	int              rec_len  [MAX_REC];
	logic [31:0]     rec_bits [MAX_REC];
	int              rec_x    [MAX_REC];
	int              rec_y    [MAX_REC];
	logic            rec_err  [MAX_REC];
	int              rec_count;

	// one entry per out_valid or code_error pulse
	logic    got_valid_q [$];
	logic    got_err_q [$];
	sample_t got_x_q   [$];
	sample_t got_y_q   [$];

	int          errors;
	int          checks;
	logic [31:0] lcg_state;
	bit          file_ok;

	huff18_decoder i_dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_bit     (in_bit),
		.out_valid  (out_valid),
		.x_val      (x_val),
		.y_val      (y_val),
		.code_error (code_error)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (!rst && (out_valid || code_error)) begin
			got_valid_q.push_back(out_valid);
			got_err_q.push_back(code_error);
			got_x_q.push_back(x_val);
			got_y_q.push_back(y_val);
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic load_golden(output bit ok);
		int              fd;
		int              r;
		bit              done;
		logic [8*24-1:0] tok;
		logic [8*96-1:0] rest;
		int              len_v, x_v, y_v, err_v;
		logic [31:0]     bits_v;
		fd = $fopen("bench/huff18_golden.txt", "r");
		ok = (fd != 0);
		rec_count = 0;
		done = !ok;
		while (!done) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				done = 1'b1;
			else if (tok == "#")
				r = $fgets(rest, fd);   // skip the column description
			else begin
				r = $fscanf(fd, "%d %b %d %d %d", len_v, bits_v, x_v, y_v, err_v);
				if (r != 5 || rec_count == MAX_REC) begin
					$display("golden line for test %0s is malformed or over the limit", tok);
					errors++;
					done = 1'b1;
				end else begin
					rec_name[rec_count] = tok;
					rec_len[rec_count] = len_v;
					rec_bits[rec_count] = bits_v;
					rec_x[rec_count] = x_v;
					rec_y[rec_count] = y_v;
					rec_err[rec_count] = (err_v != 0);
					rec_count++;
				end
			end
		end
		if (ok)
			$fclose(fd);
	endtask

	task automatic drive_records(input bit with_gaps);
		int i;
		int b;
		int g;
		for (i = 0; i < rec_count; i++) begin
			for (b = rec_len[i] - 1; b >= 0; b--) begin   // leftmost bit goes first
				g = 0;
				if (with_gaps) begin
					lcg_state = lcg_next(lcg_state);
					g = lcg_state[17:16];
				end
				repeat (g) begin
					@(negedge clk);
					in_valid = 1'b0;
				end
				@(negedge clk);
				in_valid = 1'b1;
				in_bit = rec_bits[i][b];
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_bit = 1'b0;
	endtask

	task automatic check_records();
		int      i;
		int      waited;
		bit      stop;
		logic    v;
		logic    e;
		sample_t xg, yg;
		stop = 1'b0;
		for (i = 0; i < rec_count && !stop; i++) begin
			waited = 0;
			while (got_err_q.size() == 0 && waited < TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			if (got_err_q.size() == 0) begin
				$display("no output within %0d cycles for test %0s", TIMEOUT, rec_name[i]);
				errors++;
				stop = 1'b1;
			end else begin
				v = got_valid_q.pop_front();
				e = got_err_q.pop_front();
				xg = got_x_q.pop_front();
				yg = got_y_q.pop_front();
				checks += 2;
				assert (v == !rec_err[i]) else begin
					$display("CHECK FAILED %0s out_valid expected %0d actual %0d",
						rec_name[i], !rec_err[i], v);
					errors++;
				end
				assert (e == rec_err[i]) else begin
					$display("CHECK FAILED %0s code_error expected %0d actual %0d",
						rec_name[i], rec_err[i], e);
					errors++;
				end
				if (!rec_err[i] && !e) begin
					checks += 2;
					assert (xg == sample_t'(rec_x[i])) else begin
						$display("CHECK FAILED %0s x expected %0d actual %0d",
							rec_name[i], rec_x[i], xg);
						errors++;
					end
					assert (yg == sample_t'(rec_y[i])) else begin
						$display("CHECK FAILED %0s y expected %0d actual %0d",
							rec_name[i], rec_y[i], yg);
						errors++;
					end
				end
			end
		end
	endtask

	task automatic run_pass(input bit with_gaps);
		fork
			drive_records(with_gaps);
			check_records();
		join
		repeat (4) @(negedge clk);
		if (got_err_q.size() != 0) begin
			$display("%0d outputs appeared that no test asked for", got_err_q.size());
			errors++;
			got_valid_q.delete();
			got_err_q.delete();
			got_x_q.delete();
			got_y_q.delete();
		end
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_bit = 1'b0;
		errors = 0;
		checks = 0;
		lcg_state = 32'd78617;
		load_golden(file_ok);
		repeat (8) @(negedge clk);
		rst = 1'b0;
		if (!file_ok) begin
			$display("could not open the golden file bench/huff18_golden.txt");
			errors++;
		end else if (rec_count == 0) begin
			$display("the golden file holds no test records");
			errors++;
		end else begin
			run_pass(1'b0);   // back to back, bits land in the output cycle
			run_pass(1'b1);
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/huff18_pkg.sv
verilog/huff18_table.sv
verilog/hcode_matcher.sv
verilog/tail_parser.sv
verilog/huff18_decoder.sv
bench/tb_huff18_decoder.sv

//--- Bender.yml
package:
  name: huff18_decoder

sources:
  - include_dirs:
      - include
    files:
      - verilog/huff18_pkg.sv
      - verilog/huff18_table.sv
      - verilog/hcode_matcher.sv
      - verilog/tail_parser.sv
      - verilog/huff18_decoder.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_huff18_decoder.sv

//--- bench/huff18_golden.txt
# name nbits bits(first sent bit on the left) x y code_error
# tail bits follow the codeword: x linbits, x sign, y linbits, y sign
zero_pair 1 1 0 0 0
x1_pos 4 0110 1 0 0
x1_neg 4 0111 -1 0 0
y1_neg 5 01011 0 -1 0
xy1_pos_neg 6 010001 1 -1 0
xy1_neg_pos 6 010010 -1 1 0
xy1_neg_neg 6 010011 -1 -1 0
y2_pos 7 0011100 0 2 0
x2_neg 7 0011111 -2 0 0
xy22 9 001011101 2 -2 0
x1y3 9 001010010 -1 3 0
esc_both_a 16 0000001110100111 20 -18 0
esc_both_b 16 0000001111110000 -22 15 0
esc_both_min 16 0000001100000000 15 15 0
esc_y 13 0000100111100 -1 21 0
esc_x 13 0000101001011 -17 -1 0
esc_y_zero_x 13 0000100011110 0 22 0
esc_x_zero_y 13 0000011000001 -15 0 0
long_y6 11 00011011101 0 -6 0
long_45 12 000110010101 4 -5 0
long_esc 15 000000010010011 -10 -16 0
err_zeros 10 0000000000 0 0 1
after_err 1 1 0 0 0
err_0101 10 0000000101 0 0 1
after_err2 6 010011 -1 -1 0
tail_zero 1 1 0 0 0
